//--- sim.f
hdl/bp_cce_uc_pkg.sv
hdl/bp_cce_uc_req_if.sv
hdl/bp_cce_uc_req_ingress.sv
hdl/bp_cce_uc_req_fifo.sv
hdl/bp_cce_uc_issue.sv
hdl/bp_cce_uc_mem_rev_pipe.sv
hdl/bp_cce_uc.sv
verification/bp_cce_uc_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module bp_cce_uc_tb -f sim.f -o sim_bp_cce_uc

./obj_dir/sim_bp_cce_uc | tee sim.log

if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run passed"

//--- verification/bp_cce_uc_tb.sv
`timescale 1ns/10ps

module bp_cce_uc_tb
  import bp_cce_uc_pkg::*;
  ();

  localparam int credits_lp = 2;
  localparam int timeout_lp = 200;
  localparam int drain_timeout_lp = 2000;
  localparam int key_width_lp = paddr_width_gp - 3;

  typedef struct packed {
    bp_mem_msg_e                 msg_type;
    logic [paddr_width_gp-1:0]   addr;
    bp_msg_size_e                size;
    logic [lce_id_width_gp-1:0]  id;
    logic [dword_width_gp-1:0]   data;
  } mem_msg_t;

  typedef struct packed {
    bp_lce_cmd_type_e            msg_type;
    logic [paddr_width_gp-1:0]   addr;
    bp_msg_size_e                size;
    logic [lce_id_width_gp-1:0]  dst;
    logic [dword_width_gp-1:0]   data;
  } lce_cmd_t;

  logic clk_i;
  logic reset_i;

  bp_lce_req_type_e            lce_req_msg_type_i;
  logic [paddr_width_gp-1:0]   lce_req_addr_i;
  bp_msg_size_e                lce_req_size_i;
  logic [lce_id_width_gp-1:0]  lce_req_src_i;
  logic [dword_width_gp-1:0]   lce_req_data_i;
  logic                        lce_req_v_i;
  logic                        lce_req_ready_and_o;

  bp_mem_msg_e                 mem_fwd_msg_type_o;
  logic [paddr_width_gp-1:0]   mem_fwd_addr_o;
  bp_msg_size_e                mem_fwd_size_o;
  logic [lce_id_width_gp-1:0]  mem_fwd_id_o;
  logic [dword_width_gp-1:0]   mem_fwd_data_o;
  logic                        mem_fwd_v_o;
  logic                        mem_fwd_ready_and_i;

  bp_mem_msg_e                 mem_rev_msg_type_i;
  logic [paddr_width_gp-1:0]   mem_rev_addr_i;
  bp_msg_size_e                mem_rev_size_i;
  logic [lce_id_width_gp-1:0]  mem_rev_id_i;
  logic [dword_width_gp-1:0]   mem_rev_data_i;
  logic                        mem_rev_v_i;
  logic                        mem_rev_ready_and_o;

  bp_lce_cmd_type_e            lce_cmd_msg_type_o;
  logic [paddr_width_gp-1:0]   lce_cmd_addr_o;
  bp_msg_size_e                lce_cmd_size_o;
  logic [lce_id_width_gp-1:0]  lce_cmd_dst_o;
  logic [dword_width_gp-1:0]   lce_cmd_data_o;
  logic                        lce_cmd_v_o;
  logic                        lce_cmd_ready_and_i;

  // memory model contents and the shadow copy used for predictions
  logic [63:0] mem [logic [key_width_lp-1:0]];
  logic [63:0] ref_mem [logic [key_width_lp-1:0]];

  mem_msg_t exp_fwd_q[$];
  lce_cmd_t exp_cmd_q[$];
  mem_msg_t rsp_q[$];

  // traffic control that changes only on the falling edge
  logic fwd_stall = 1'b0;
  logic cmd_stall = 1'b0;
  logic hold_rsp = 1'b0;
  logic rand_bp = 1'b0;

  logic fwd_fire;
  logic rev_fire;
  int fwd_count = 0;
  int rev_count = 0;
  int rev_delay = 0;
  mem_msg_t act_fwd;
  mem_msg_t exp_fwd;
  lce_cmd_t act_cmd;
  lce_cmd_t exp_cmd;
  string test_name = "reset";

  bp_cce_uc
    #(.req_fifo_els_p(4)
      ,.mem_credits_p(credits_lp)
      )
    u_dut
     (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // each dword address gets its own pattern
  function automatic logic [63:0] fill_word(input logic [key_width_lp-1:0] key);
    return {key[26:0], key} ^ 64'h3c5a_96e1_0f2d_b487;
  endfunction

  function automatic logic [63:0] model_word(input logic [key_width_lp-1:0] key);
    return mem.exists(key) ? mem[key] : fill_word(key);
  endfunction

  function automatic logic [63:0] shadow_word(input logic [key_width_lp-1:0] key);
    return ref_mem.exists(key) ? ref_mem[key] : fill_word(key);
  endfunction

  // low size bytes repeated over the dword
  function automatic logic [63:0] replicate(input logic [63:0] data, input bp_msg_size_e size);
    logic [63:0] word;
    int n;
    n = 1 << size;
    for (int i = 0; i < 8; i++) begin
      word[i*8 +: 8] = data[(i % n)*8 +: 8];
    end
    return word;
  endfunction

  function automatic logic [63:0] merge_word(input logic [63:0] old, input logic [63:0] data,
                                             input logic [paddr_width_gp-1:0] addr,
                                             input bp_msg_size_e size);
    logic [63:0] word;
    int n;
    int off;
    word = old;
    n = 1 << size;
    off = int'(addr[2:0]);
    for (int i = 0; i < 8; i++) begin
      if (i >= off && i < off + n) begin
        word[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    return word;
  endfunction

  // reference model for the forward message of one request
  function automatic mem_msg_t predict_fwd(input bp_lce_req_type_e t,
                                           input logic [paddr_width_gp-1:0] addr,
                                           input bp_msg_size_e size,
                                           input logic [lce_id_width_gp-1:0] src,
                                           input logic [63:0] data);
    mem_msg_t f;
    f.msg_type = (t == e_req_uc_wr) ? e_mem_uc_wr : e_mem_uc_rd;
    f.addr = addr;
    f.size = size;
    f.id = src;
    f.data = (t == e_req_uc_wr) ? replicate(data, size) : 64'h0;
    return f;
  endfunction

  function automatic lce_cmd_t predict_cmd(input mem_msg_t f, input logic [63:0] word);
    lce_cmd_t c;
    c.msg_type = (f.msg_type == e_mem_uc_wr) ? e_cmd_uc_st_done : e_cmd_uc_data;
    c.addr = f.addr;
    c.size = f.size;
    c.dst = f.id;
    c.data = (f.msg_type == e_mem_uc_wr) ? 64'h0 : word;
    return c;
  endfunction

  // memory applies a store or reads the dword and echoes the message back
  function automatic mem_msg_t serve_mem(input mem_msg_t m);
    mem_msg_t rsp;
    logic [key_width_lp-1:0] key;
    key = m.addr[paddr_width_gp-1:3];
    rsp = m;
    if (m.msg_type == e_mem_uc_wr) begin
      mem[key] = merge_word(model_word(key), m.data, m.addr, m.size);
    end else begin
      rsp.data = model_word(key);
    end
    return rsp;
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1, "first error seen");
  endtask

  task automatic report_error(input string why);
    stop_run($sformatf("Error in %s: %s", test_name, why));
  endtask

  task automatic check_mem_fwd(input mem_msg_t exp, input mem_msg_t act);
    if (act !== exp) begin
      stop_run($sformatf(
        "Mismatch in %s: mem_fwd expected %0d/%h/%0d/%h/%h actual %0d/%h/%0d/%h/%h",
        test_name, exp.msg_type, exp.addr, exp.size, exp.id, exp.data,
        act.msg_type, act.addr, act.size, act.id, act.data));
    end
  endtask

  task automatic check_lce_cmd(input lce_cmd_t exp, input lce_cmd_t act);
    if (act !== exp) begin
      stop_run($sformatf(
        "Mismatch in %s: lce_cmd expected %0d/%h/%0d/%h/%h actual %0d/%h/%0d/%h/%h",
        test_name, exp.msg_type, exp.addr, exp.size, exp.dst, exp.data,
        act.msg_type, act.addr, act.size, act.dst, act.data));
    end
  endtask

  // outputs sampled at the falling edge before the rising edge that transfers them
  always @(negedge clk_i) begin
    if (reset_i) begin
      fwd_fire = 1'b0;
      rev_fire = 1'b0;
    end else begin
      fwd_fire = mem_fwd_v_o & mem_fwd_ready_and_i;
      rev_fire = mem_rev_v_i & mem_rev_ready_and_o;
      if (fwd_fire) begin
        act_fwd.msg_type = mem_fwd_msg_type_o;
        act_fwd.addr = mem_fwd_addr_o;
        act_fwd.size = mem_fwd_size_o;
        act_fwd.id = mem_fwd_id_o;
        act_fwd.data = mem_fwd_data_o;
        if (exp_fwd_q.size() == 0) begin
          report_error("memory forward message with no request pending");
        end
        exp_fwd = exp_fwd_q.pop_front();
        check_mem_fwd(exp_fwd, act_fwd);
        rsp_q.push_back(serve_mem(act_fwd));
        fwd_count++;
      end
      if (rev_fire) begin
        rev_count++;
      end
      if (fwd_count - rev_count > credits_lp) begin
        report_error("more memory requests outstanding than credits");
      end
      if (lce_cmd_v_o && lce_cmd_ready_and_i) begin
        act_cmd.msg_type = lce_cmd_msg_type_o;
        act_cmd.addr = lce_cmd_addr_o;
        act_cmd.size = lce_cmd_size_o;
        act_cmd.dst = lce_cmd_dst_o;
        act_cmd.data = lce_cmd_data_o;
        if (exp_cmd_q.size() == 0) begin
          report_error("LCE command with no response pending");
        end
        exp_cmd = exp_cmd_q.pop_front();
        check_lce_cmd(exp_cmd, act_cmd);
      end
    end
  end

  // memory answers in order after a short random delay each
  always @(posedge clk_i) begin
    if (reset_i) begin
      mem_rev_v_i <= 1'b0;
      rev_delay = 0;
    end else begin
      if (rev_fire) begin
        rsp_q.delete(0);
        rev_delay = int'($urandom_range(0, 3));
      end
      if (!(mem_rev_v_i && !rev_fire)) begin
        if (rsp_q.size() != 0 && rev_delay == 0 && !hold_rsp) begin
          mem_rev_msg_type_i <= rsp_q[0].msg_type;
          mem_rev_addr_i <= rsp_q[0].addr;
          mem_rev_size_i <= rsp_q[0].size;
          mem_rev_id_i <= rsp_q[0].id;
          mem_rev_data_i <= rsp_q[0].data;
          mem_rev_v_i <= 1'b1;
        end else begin
          mem_rev_v_i <= 1'b0;
          if (rev_delay != 0) begin
            rev_delay--;
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    mem_fwd_ready_and_i <= !fwd_stall && (!rand_bp || $urandom_range(0, 3) != 0);
    lce_cmd_ready_and_i <= !cmd_stall && (!rand_bp || $urandom_range(0, 3) != 0);
  end

  // queue the predictions before presenting the request
  task automatic drive_req(input bp_lce_req_type_e t, input logic [paddr_width_gp-1:0] addr,
                           input bp_msg_size_e size, input logic [lce_id_width_gp-1:0] src,
                           input logic [63:0] data);
    mem_msg_t f;
    logic [key_width_lp-1:0] key;
    logic [63:0] old;
    f = predict_fwd(t, addr, size, src, data);
    key = addr[paddr_width_gp-1:3];
    old = shadow_word(key);
    exp_fwd_q.push_back(f);
    exp_cmd_q.push_back(predict_cmd(f, old));
    if (t == e_req_uc_wr) begin
      ref_mem[key] = merge_word(old, f.data, addr, size);
    end
    @(posedge clk_i);
    lce_req_msg_type_i <= t;
    lce_req_addr_i <= addr;
    lce_req_size_i <= size;
    lce_req_src_i <= src;
    lce_req_data_i <= data;
    lce_req_v_i <= 1'b1;
  endtask

  task automatic wait_req_accept();
    int waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > timeout_lp) begin
        report_error("timeout waiting for the LCE request to be accepted");
      end
    end while (!lce_req_ready_and_o);
    @(posedge clk_i);
    lce_req_v_i <= 1'b0;
  endtask

  task automatic send_req(input bp_lce_req_type_e t, input logic [paddr_width_gp-1:0] addr,
                          input bp_msg_size_e size, input logic [lce_id_width_gp-1:0] src,
                          input logic [63:0] data);
    drive_req(t, addr, size, src, data);
    wait_req_accept();
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_fwd_q.size() != 0 || exp_cmd_q.size() != 0 || rsp_q.size() != 0
           || lce_cmd_v_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > drain_timeout_lp) begin
        report_error("timeout waiting for outstanding traffic to drain");
      end
    end
  endtask

  task automatic load_each_size();
    logic [2:0] offs [4];
    offs = '{3'd3, 3'd6, 3'd4, 3'd0};
    test_name = "uc_loads";
    for (int s = 0; s < 4; s++) begin
      send_req(e_req_uc_rd, 40'h00_4000_0000 + 40'(8 * s) + 40'(offs[s]),
               bp_msg_size_e'(s), 4'(s + 1), 64'hdead_beef_0bad_f00d);
    end
    wait_drain();
  endtask

  // each store is read back as a full dword
  task automatic store_each_size();
    logic [2:0] offs [4];
    logic [paddr_width_gp-1:0] base;
    offs = '{3'd5, 3'd2, 3'd4, 3'd0};
    test_name = "uc_stores";
    for (int s = 0; s < 4; s++) begin
      base = 40'h00_5000_0000 + 40'(8 * s);
      send_req(e_req_uc_wr, base + 40'(offs[s]), bp_msg_size_e'(s), 4'(s + 8),
               {$urandom, $urandom});
      send_req(e_req_uc_rd, base, e_size_8, 4'(s + 12), 64'h0);
    end
    wait_drain();
  endtask

  task automatic fwd_backpressure();
    test_name = "fwd_backpressure";
    @(negedge clk_i);
    fwd_stall = 1'b1;
    for (int i = 0; i < 5; i++) begin
      send_req((i % 2 == 0) ? e_req_uc_wr : e_req_uc_rd, 40'h00_6000_0000 + 40'(8 * i),
               e_size_8, 4'(i), {$urandom, $urandom});
    end
    // fifo and output register are both full by now
    drive_req(e_req_uc_rd, 40'h00_6000_0000, e_size_8, 4'd5, 64'h0);
    repeat (8) begin
      @(negedge clk_i);
      if (lce_req_ready_and_o) begin
        report_error("request accepted while memory forward was stalled and full");
      end
    end
    fwd_stall = 1'b0;
    wait_req_accept();
    wait_drain();
  endtask

  task automatic credit_exhaustion();
    int waited;
    int base;
    test_name = "credit_limit";
    @(negedge clk_i);
    hold_rsp = 1'b1;
    base = fwd_count;
    for (int i = 0; i < 4; i++) begin
      send_req(e_req_uc_rd, 40'h00_7000_0000 + 40'(8 * i), e_size_4, 4'(i + 2), 64'h0);
    end
    waited = 0;
    while (fwd_count < base + credits_lp) begin
      @(negedge clk_i);
      waited++;
      if (waited > timeout_lp) begin
        report_error("timeout waiting for the first memory requests");
      end
    end
    repeat (16) begin
      @(negedge clk_i);
      if (fwd_count != base + credits_lp) begin
        report_error("memory request accepted with no credit left");
      end
    end
    hold_rsp = 1'b0;
    wait_drain();
  endtask

  task automatic cmd_backpressure();
    int waited;
    test_name = "cmd_backpressure";
    @(negedge clk_i);
    cmd_stall = 1'b1;
    for (int i = 0; i < 4; i++) begin
      send_req(e_req_uc_rd, 40'h00_5000_0000 + 40'(8 * i), e_size_8, 4'(i + 4), 64'h0);
    end
    waited = 0;
    while (!(mem_rev_v_i && !mem_rev_ready_and_o)) begin
      @(negedge clk_i);
      waited++;
      if (waited > timeout_lp) begin
        report_error("memory response ready never dropped while commands were stalled");
      end
    end
    cmd_stall = 1'b0;
    wait_drain();
  endtask

  task automatic random_traffic();
    bp_msg_size_e size;
    logic [2:0] off;
    test_name = "random_mix";
    @(negedge clk_i);
    rand_bp = 1'b1;
    for (int i = 0; i < 300; i++) begin
      size = bp_msg_size_e'($urandom_range(0, 3));
      off = 3'($urandom_range(0, 7)) & ~3'((1 << size) - 1);
      send_req(($urandom_range(0, 1) == 1) ? e_req_uc_wr : e_req_uc_rd,
               40'h80_0000_0000 + 40'(8 * $urandom_range(0, 15)) + 40'(off),
               size, 4'($urandom_range(0, 15)), {$urandom, $urandom});
    end
    wait_drain();
    rand_bp = 1'b0;
  endtask

  initial begin
    void'($urandom(32'hb717_f75d));
    reset_i = 1'b1;
    lce_req_msg_type_i = e_req_uc_rd;
    lce_req_addr_i = '0;
    lce_req_size_i = e_size_8;
    lce_req_src_i = '0;
    lce_req_data_i = '0;
    lce_req_v_i = 1'b0;
    mem_fwd_ready_and_i = 1'b0;
    mem_rev_msg_type_i = e_mem_uc_rd;
    mem_rev_addr_i = '0;
    mem_rev_size_i = e_size_8;
    mem_rev_id_i = '0;
    mem_rev_data_i = '0;
    mem_rev_v_i = 1'b0;
    lce_cmd_ready_and_i = 1'b0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    load_each_size();
    store_each_size();
    fwd_backpressure();
    credit_exhaustion();
    cmd_backpressure();
    random_traffic();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- hdl/bp_cce_uc.sv
`timescale 1ns/10ps

module bp_cce_uc
  import bp_cce_uc_pkg::*;
  #(parameter int req_fifo_els_p = 4
    , parameter int mem_credits_p = 2
    )
  (input                                     clk_i
   , input                                   reset_i

   // lce request, ready&valid
   , input bp_lce_req_type_e                 lce_req_msg_type_i
   , input [paddr_width_gp-1:0]              lce_req_addr_i
   , input bp_msg_size_e                     lce_req_size_i
   , input [lce_id_width_gp-1:0]             lce_req_src_i
   , input [dword_width_gp-1:0]              lce_req_data_i
   , input                                   lce_req_v_i
   , output logic                            lce_req_ready_and_o

   // memory forward, ready&valid
   , output bp_mem_msg_e                     mem_fwd_msg_type_o
   , output logic [paddr_width_gp-1:0]       mem_fwd_addr_o
   , output bp_msg_size_e                    mem_fwd_size_o
   , output logic [lce_id_width_gp-1:0]      mem_fwd_id_o
   , output logic [dword_width_gp-1:0]       mem_fwd_data_o
   , output logic                            mem_fwd_v_o
   , input                                   mem_fwd_ready_and_i

   // memory response, ready&valid
   , input bp_mem_msg_e                      mem_rev_msg_type_i
   , input [paddr_width_gp-1:0]              mem_rev_addr_i
   , input bp_msg_size_e                     mem_rev_size_i
   , input [lce_id_width_gp-1:0]             mem_rev_id_i
   , input [dword_width_gp-1:0]              mem_rev_data_i
   , input                                   mem_rev_v_i
   , output logic                            mem_rev_ready_and_o

   // lce command, ready&valid
   , output bp_lce_cmd_type_e                lce_cmd_msg_type_o
   , output logic [paddr_width_gp-1:0]       lce_cmd_addr_o
   , output bp_msg_size_e                    lce_cmd_size_o
   , output logic [lce_id_width_gp-1:0]      lce_cmd_dst_o
   , output logic [dword_width_gp-1:0]       lce_cmd_data_o
   , output logic                            lce_cmd_v_o
   , input                                   lce_cmd_ready_and_i
   );

  bp_cce_uc_req_if ingress_if ();
  bp_cce_uc_req_if issue_if ();

  logic issue_credit_return;

  bp_cce_uc_req_ingress ingress
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.lce_req_msg_type_i(lce_req_msg_type_i)
     ,.lce_req_addr_i(lce_req_addr_i)
     ,.lce_req_size_i(lce_req_size_i)
     ,.lce_req_src_i(lce_req_src_i)
     ,.lce_req_data_i(lce_req_data_i)
     ,.lce_req_v_i(lce_req_v_i)
     ,.lce_req_ready_and_o(lce_req_ready_and_o)
     ,.out_o(ingress_if.producer)
     );

  bp_cce_uc_req_fifo
    #(.els_p(req_fifo_els_p))
    req_fifo
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.in_i(ingress_if.consumer)
      ,.out_o(issue_if.producer)
      );

  bp_cce_uc_issue
    #(.credits_p(mem_credits_p))
    issue
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.in_i(issue_if.consumer)
      ,.credit_return_i(issue_credit_return)
      ,.mem_fwd_msg_type_o(mem_fwd_msg_type_o)
      ,.mem_fwd_addr_o(mem_fwd_addr_o)
      ,.mem_fwd_size_o(mem_fwd_size_o)
      ,.mem_fwd_id_o(mem_fwd_id_o)
      ,.mem_fwd_data_o(mem_fwd_data_o)
      ,.mem_fwd_v_o(mem_fwd_v_o)
      ,.mem_fwd_ready_and_i(mem_fwd_ready_and_i)
      );

  // responses turn into commands and free credits
  bp_cce_uc_mem_rev_pipe mem_rev_pipe
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.mem_rev_msg_type_i(mem_rev_msg_type_i)
     ,.mem_rev_addr_i(mem_rev_addr_i)
     ,.mem_rev_size_i(mem_rev_size_i)
     ,.mem_rev_id_i(mem_rev_id_i)
     ,.mem_rev_data_i(mem_rev_data_i)
     ,.mem_rev_v_i(mem_rev_v_i)
     ,.mem_rev_ready_and_o(mem_rev_ready_and_o)
     ,.lce_cmd_msg_type_o(lce_cmd_msg_type_o)
     ,.lce_cmd_addr_o(lce_cmd_addr_o)
     ,.lce_cmd_size_o(lce_cmd_size_o)
     ,.lce_cmd_dst_o(lce_cmd_dst_o)
     ,.lce_cmd_data_o(lce_cmd_data_o)
     ,.lce_cmd_v_o(lce_cmd_v_o)
     ,.lce_cmd_ready_and_i(lce_cmd_ready_and_i)
     ,.credit_return_o(issue_credit_return)
     );

endmodule

//--- hdl/bp_cce_uc_mem_rev_pipe.sv
`timescale 1ns/10ps

module bp_cce_uc_mem_rev_pipe
  import bp_cce_uc_pkg::*;
  (input                                     clk_i
   , input                                   reset_i

   // memory response, ready&valid
   , input bp_mem_msg_e                      mem_rev_msg_type_i
   , input [paddr_width_gp-1:0]              mem_rev_addr_i
   , input bp_msg_size_e                     mem_rev_size_i
   , input [lce_id_width_gp-1:0]             mem_rev_id_i
   , input [dword_width_gp-1:0]              mem_rev_data_i
   , input                                   mem_rev_v_i
   , output logic                            mem_rev_ready_and_o

   // lce command, ready&valid
   , output bp_lce_cmd_type_e                lce_cmd_msg_type_o
   , output logic [paddr_width_gp-1:0]       lce_cmd_addr_o
   , output bp_msg_size_e                    lce_cmd_size_o
   , output logic [lce_id_width_gp-1:0]      lce_cmd_dst_o
   , output logic [dword_width_gp-1:0]       lce_cmd_data_o
   , output logic                            lce_cmd_v_o
   , input                                   lce_cmd_ready_and_i

   // back to the issue stage
   , output logic                            credit_return_o
   );

  logic rev_accept;
  logic is_read;

  // single entry that refills in the cycle it drains
  assign mem_rev_ready_and_o = ~lce_cmd_v_o | lce_cmd_ready_and_i;
  assign rev_accept          = mem_rev_v_i & mem_rev_ready_and_o;
  assign credit_return_o     = rev_accept;

  assign is_read = (mem_rev_msg_type_i == e_mem_uc_rd);

  always_ff @(posedge clk_i) begin
    if (rev_accept) begin
      lce_cmd_msg_type_o <= is_read ? e_cmd_uc_data : e_cmd_uc_st_done;
      lce_cmd_addr_o     <= mem_rev_addr_i;
      lce_cmd_size_o     <= mem_rev_size_i;
      lce_cmd_dst_o      <= mem_rev_id_i;
      // store done carries no data
      lce_cmd_data_o     <= is_read ? mem_rev_data_i : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lce_cmd_v_o <= 1'b0;
    end else if (rev_accept) begin
      lce_cmd_v_o <= 1'b1;
    end else if (lce_cmd_ready_and_i) begin
      lce_cmd_v_o <= 1'b0;
    end
  end

  // memory must hold a response until it is taken
  a_rev_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    mem_rev_v_i && !mem_rev_ready_and_o |=> mem_rev_v_i
      && $stable({mem_rev_msg_type_i, mem_rev_addr_i, mem_rev_size_i,
                  mem_rev_id_i, mem_rev_data_i}))
    else $error("memory response changed while stalled");

endmodule

//--- hdl/bp_cce_uc_issue.sv
`timescale 1ns/10ps

module bp_cce_uc_issue
  import bp_cce_uc_pkg::*;
  #(parameter int credits_p = 2)
  (input                                     clk_i
   , input                                   reset_i

   , bp_cce_uc_req_if.consumer               in_i
   // one pulse per memory response
   , input                                   credit_return_i

   // memory forward, ready&valid
   , output bp_mem_msg_e                     mem_fwd_msg_type_o
   , output logic [paddr_width_gp-1:0]       mem_fwd_addr_o
   , output bp_msg_size_e                    mem_fwd_size_o
   , output logic [lce_id_width_gp-1:0]      mem_fwd_id_o
   , output logic [dword_width_gp-1:0]       mem_fwd_data_o
   , output logic                            mem_fwd_v_o
   , input                                   mem_fwd_ready_and_i
   );

  localparam int cnt_width_lp = $clog2(credits_p + 1);
  localparam logic [cnt_width_lp-1:0] max_cnt_lp  = cnt_width_lp'(credits_p);
  localparam logic [cnt_width_lp-1:0] last_cnt_lp = cnt_width_lp'(credits_p - 1);

  logic [cnt_width_lp-1:0] outstanding_r;
  logic                    fwd_accept, pop;

  assign fwd_accept = mem_fwd_v_o & mem_fwd_ready_and_i;

  // message in the output register already holds a credit
  assign in_i.ready_and = mem_fwd_v_o
                        ? (mem_fwd_ready_and_i & (outstanding_r < last_cnt_lp))
                        : (outstanding_r < max_cnt_lp);
  assign pop = in_i.v & in_i.ready_and;

  // output register payload
  always_ff @(posedge clk_i) begin
    if (pop) begin
      mem_fwd_msg_type_o <= (in_i.msg_type == e_req_uc_wr) ? e_mem_uc_wr : e_mem_uc_rd;
      mem_fwd_addr_o     <= in_i.addr;
      mem_fwd_size_o     <= in_i.size;
      // requester id rides along and comes back on the response
      mem_fwd_id_o       <= in_i.src_id;
      mem_fwd_data_o     <= in_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_fwd_v_o <= 1'b0;
    end else if (pop) begin
      mem_fwd_v_o <= 1'b1;
    end else if (fwd_accept) begin
      mem_fwd_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_r <= '0;
    end else begin
      unique case ({fwd_accept, credit_return_i})
        2'b10:   outstanding_r <= outstanding_r + 1'b1;
        2'b01:   outstanding_r <= outstanding_r - 1'b1;
        default: outstanding_r <= outstanding_r;
      endcase
    end
  end

  a_credit_limit : assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding_r <= max_cnt_lp)
    else $error("memory credits exceeded");

  // responses only for requests memory has taken
  a_credit_source : assert property (@(posedge clk_i) disable iff (reset_i)
    credit_return_i |-> (outstanding_r != '0))
    else $error("credit returned with nothing outstanding");

endmodule

//--- hdl/bp_cce_uc_req_fifo.sv
`timescale 1ns/10ps

module bp_cce_uc_req_fifo
  import bp_cce_uc_pkg::*;
  #(parameter int els_p = 4)
  (input                         clk_i
   , input                       reset_i

   , bp_cce_uc_req_if.consumer   in_i
   , bp_cce_uc_req_if.producer   out_o
   );

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lp = $clog2(els_p + 1);
  localparam logic [ptr_width_lp-1:0] last_ptr_lp = ptr_width_lp'(els_p - 1);
  localparam logic [cnt_width_lp-1:0] full_cnt_lp = cnt_width_lp'(els_p);

  // entry storage with one array per field
  bp_lce_req_type_e           type_mem [els_p];
  logic [paddr_width_gp-1:0]  addr_mem [els_p];
  bp_msg_size_e               size_mem [els_p];
  logic [lce_id_width_gp-1:0] src_mem  [els_p];
  logic [dword_width_gp-1:0]  data_mem [els_p];

  logic [ptr_width_lp-1:0] wr_ptr_r, rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    full, empty, push, pop;

  assign full  = (count_r == full_cnt_lp);
  assign empty = (count_r == '0);
  assign push  = in_i.v & in_i.ready_and;
  assign pop   = out_o.v & out_o.ready_and;

  // a full fifo still takes a request when the head leaves
  assign in_i.ready_and = ~full | out_o.ready_and;

  always_ff @(posedge clk_i) begin
    if (push) begin
      type_mem[wr_ptr_r] <= in_i.msg_type;
      addr_mem[wr_ptr_r] <= in_i.addr;
      size_mem[wr_ptr_r] <= in_i.size;
      src_mem[wr_ptr_r]  <= in_i.src_id;
      data_mem[wr_ptr_r] <= in_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == last_ptr_lp) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == last_ptr_lp) ? '0 : rd_ptr_r + 1'b1;
      end
      if (push & ~pop) begin
        count_r <= count_r + 1'b1;
      end else if (pop & ~push) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  // head of queue
  assign out_o.v        = ~empty;
  assign out_o.msg_type = type_mem[rd_ptr_r];
  assign out_o.addr     = addr_mem[rd_ptr_r];
  assign out_o.size     = size_mem[rd_ptr_r];
  assign out_o.src_id   = src_mem[rd_ptr_r];
  assign out_o.data     = data_mem[rd_ptr_r];

  // occupancy never runs past the depth
  a_no_overflow : assert property (@(posedge clk_i) disable iff (reset_i)
    count_r <= full_cnt_lp)
    else $error("request fifo overflow");

  // pointers meet only when the fifo is empty or full
  a_ptr_count : assert property (@(posedge clk_i) disable iff (reset_i)
    (wr_ptr_r == rd_ptr_r) == (empty || full))
    else $error("request fifo pointers out of step with occupancy");

endmodule

//--- hdl/bp_cce_uc_req_ingress.sv
`timescale 1ns/10ps

module bp_cce_uc_req_ingress
  import bp_cce_uc_pkg::*;
  (input                                clk_i
   , input                              reset_i

   // lce request, ready&valid
   , input bp_lce_req_type_e            lce_req_msg_type_i
   , input [paddr_width_gp-1:0]         lce_req_addr_i
   , input bp_msg_size_e                lce_req_size_i
   , input [lce_id_width_gp-1:0]        lce_req_src_i
   , input [dword_width_gp-1:0]         lce_req_data_i
   , input                              lce_req_v_i
   , output logic                       lce_req_ready_and_o

   // decoded request towards the fifo
   , bp_cce_uc_req_if.producer          out_o
   );

  logic [dword_width_gp-1:0] st_data;
  logic [2:0]                align_mask;

  // sub-word stores are replicated across the whole dword
  always_comb begin
    unique case (lce_req_size_i)
      e_size_1: st_data = {8{lce_req_data_i[7:0]}};
      e_size_2: st_data = {4{lce_req_data_i[15:0]}};
      e_size_4: st_data = {2{lce_req_data_i[31:0]}};
      default:  st_data = lce_req_data_i;
    endcase
  end

  assign out_o.msg_type = lce_req_msg_type_i;
  assign out_o.addr     = lce_req_addr_i;
  assign out_o.size     = lce_req_size_i;
  assign out_o.src_id   = lce_req_src_i;
  // loads carry no payload
  assign out_o.data     = (lce_req_msg_type_i == e_req_uc_wr) ? st_data : '0;
  assign out_o.v        = lce_req_v_i;

  assign lce_req_ready_and_o = out_o.ready_and;

  // low address bits that must be zero for this size
  assign align_mask = 3'((4'b0001 << lce_req_size_i) - 4'b0001);

  a_addr_aligned : assert property (@(posedge clk_i) disable iff (reset_i)
    lce_req_v_i |-> ((lce_req_addr_i[2:0] & align_mask) == 3'b000))
    else $error("unaligned uncached request");

  // sender must hold the request until it is taken
  a_req_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    lce_req_v_i && !lce_req_ready_and_o |=> lce_req_v_i
      && $stable({lce_req_msg_type_i, lce_req_addr_i, lce_req_size_i,
                  lce_req_src_i, lce_req_data_i}))
    else $error("lce request changed while stalled");

endmodule

//--- hdl/bp_cce_uc_req_if.sv
`timescale 1ns/10ps

interface bp_cce_uc_req_if
  import bp_cce_uc_pkg::*;
  ();

  // decoded uncached request
  bp_lce_req_type_e            msg_type;
  logic [paddr_width_gp-1:0]   addr;
  bp_msg_size_e                size;
  logic [lce_id_width_gp-1:0]  src_id;
  logic [dword_width_gp-1:0]   data;

  // ready&valid, v never waits on ready_and
  logic                        v;
  logic                        ready_and;

  modport producer (
    output msg_type, addr, size, src_id, data, v
    , input ready_and
  );

  modport consumer (
    input msg_type, addr, size, src_id, data, v
    , output ready_and
  );

endinterface

//--- hdl/bp_cce_uc_pkg.sv
package bp_cce_uc_pkg;

  // bedrock widths for the uncached engine
  localparam int paddr_width_gp  = 40;
  localparam int dword_width_gp  = 64;
  localparam int lce_id_width_gp = 4;

  // lce request opcodes, uncached only
  typedef enum logic [1:0] {
    e_req_uc_rd = 2'b00
    ,e_req_uc_wr = 2'b01
  } bp_lce_req_type_e;

  // memory forward and reverse opcodes
  typedef enum logic [1:0] {
    e_mem_uc_rd = 2'b00
    ,e_mem_uc_wr = 2'b01
  } bp_mem_msg_e;

  // commands sent back to the requesting lce
  typedef enum logic [1:0] {
    e_cmd_uc_data = 2'b00
    ,e_cmd_uc_st_done = 2'b01
  } bp_lce_cmd_type_e;

  // log2 of the access size in bytes
  typedef enum logic [1:0] {
    e_size_1 = 2'b00
    ,e_size_2 = 2'b01
    ,e_size_4 = 2'b10
    ,e_size_8 = 2'b11
  } bp_msg_size_e;

endpackage
